// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_quant_out
BUILD_DIR ?= obj_dir
FILELIST  ?= sim.f
LOG       ?= sim.log
PASS_MSG  ?= ALL CHECKS PASSED
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
SIM_ARGS  ?= +verilator+error+limit+100

SRCS    := $(wildcard verilog/*.sv verification/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim.f ====
verilog/quant_pkg.sv
verilog/psum_buf_pkg.sv
verilog/psum_bus_if.sv
verilog/psum_arbiter.sv
verilog/psum_writer.sv
verilog/quant_reader.sv
verilog/bit_select_16x8.sv
verilog/quant_out_top.sv
verification/quant_out_sva.sv
verification/tb_quant_out.sv

// ==== verification/quant_out_sva.sv ====
module quant_out_sva
(
    input logic                        clk,
    input logic                        rst_n,
    input logic                        i_valid,
    input logic [quant_pkg::OUT_W-1:0] i_data,
    input logic                        i_rd_busy,
    input logic                        i_wr_full,
    input logic                        i_wr_idle
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;     // read back by the testbench at the end

    zero_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !i_valid |-> i_data == '0)
    else
    begin
        $error("o_data is not zero while o_valid is low");
        fail_count++;
    end

    // last result lands two cycles after the last grant
    no_late_result: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(i_valid) |-> ($past(i_rd_busy, 1) || $past(i_rd_busy, 2) || $past(i_rd_busy, 3)))
    else
    begin
        $error("o_valid rose after o_rd_busy had been low for 3 cycles");
        fail_count++;
    end

    full_not_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !(i_wr_full && i_wr_idle))
    else
    begin
        $error("write queue reports full and idle at once");
        fail_count++;
    end

endmodule

bind quant_out_top quant_out_sva i_quant_out_sva
(
    .clk       (clk),
    .rst_n     (rst_n),
    .i_valid   (o_valid),
    .i_data    (o_data),
    .i_rd_busy (o_rd_busy),
    .i_wr_full (o_wr_full),
    .i_wr_idle (o_wr_idle)
);

// ==== verification/tb_quant_out.sv ====
module tb_quant_out;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DRIVE_DLY  = 10;     // ns after the rising edge
    localparam int WAIT_LIMIT = 200;    // cycles per wait loop
    localparam int W_IDLE     = 0;
    localparam int W_SPACE    = 1;
    localparam int W_BLOCK    = 2;
    localparam int DROP_PULSE = 7;      // burst pulse that meets a full queue

    logic                            clk;
    logic                            rst_n;
    logic                            i_wr_valid;
    logic [psum_buf_pkg::ADDR_W-1:0] i_wr_addr;
    logic [quant_pkg::DATA_W-1:0]    i_wr_data;
    logic                            o_wr_full;
    logic                            o_wr_idle;
    logic                            i_rd_start;
    logic [psum_buf_pkg::ADDR_W-1:0] i_rd_base;
    logic [psum_buf_pkg::ADDR_W-1:0] i_rd_count;
    logic [quant_pkg::CMD_W-1:0]     i_cmd;
    logic                            o_rd_busy;
    logic                            o_valid;
    logic [quant_pkg::OUT_W-1:0]     o_data;

    logic [quant_pkg::DATA_W-1:0] model [psum_buf_pkg::BUF_DEPTH];   // buffer contents
    logic [quant_pkg::OUT_W-1:0]  exp_q [$];     // outputs still owed
    logic [15:0]                  lfsr_q = 16'd20126;
    int value_errs = 0;
    int proto_errs = 0;
    int timeouts   = 0;
    int n_results  = 0;

    quant_out_top i_quant_out_top (.*);

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};    // taps 16,14,13,11
    endfunction

    function automatic logic [15:0] rand_word();
        logic [15:0] w = '0;
        for (int i = 0; i < 16; i++)
        begin
            lfsr_q = lfsr_next(lfsr_q);
            w = {w[14:0], lfsr_q[0]};   // one step per bit
        end
        return w;
    endfunction

    // window starting at bit s+1, or the low byte
    function automatic logic [7:0] select_ref(input logic [15:0] word, input logic [3:0] cmd);
        logic [15:0] shifted;
        shifted = word >> (int'(cmd[2:0]) + 1);
        if (quant_pkg::sel_mode_e'(cmd[3]) == quant_pkg::MODE_SHIFT)
            return shifted[7:0];
        return word[7:0];
    endfunction

    function automatic bit reached(input int kind);
        case (kind)
            W_IDLE:  return o_wr_idle;
            W_SPACE: return !o_wr_full;
            default: return !o_rd_busy && exp_q.size() == 0;
        endcase
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic check_eq(input string name, input logic [15:0] got, input logic [15:0] want);
        assert (got === want)
        else
        begin
            $display("CHECK FAILED %s got %h expected %h", name, got, want);
            value_errs++;
        end
    endtask

    task automatic wait_for(input int kind, input string what);
        int cycles = 0;
        while (!reached(kind) && cycles < WAIT_LIMIT)
        begin
            next_cycle();
            cycles++;
        end
        if (!reached(kind))
        begin
            $display("timeout after %0d cycles waiting for %s", cycles, what);
            timeouts++;
        end
    endtask

    task automatic write_word(input logic [3:0] addr, input logic [15:0] data);
        wait_for(W_SPACE, "room in the write queue");
        i_wr_valid = 1'b1;
        i_wr_addr  = addr;
        i_wr_data  = data;
        model[addr] = data;
        next_cycle();
        i_wr_valid = 1'b0;
    endtask

    // extra selects 0 plain, 1 second start while busy, 2 write burst during the block
    task automatic run_block(input logic [3:0] base, input logic [3:0] count,
                             input logic [3:0] cmd, input int extra);
        int          len = (count == 4'd0) ? 16 : int'(count);
        logic [15:0] wdata;
        for (int k = 0; k < len; k++)
            exp_q.push_back(select_ref(model[base + 4'(k)], cmd));
        n_results  = 0;
        i_rd_start = 1'b1;
        i_rd_base  = base;
        i_rd_count = count;
        i_cmd      = cmd;
        next_cycle();
        i_rd_start = 1'b0;
        check_eq("o_rd_busy", 16'(o_rd_busy), 16'h1);
        if (extra == 1)
        begin
            next_cycle();
            i_rd_start = 1'b1;
            i_rd_base  = base + 4'd3;
            next_cycle();
            i_rd_start = 1'b0;
        end
        if (extra == 2)
        begin
            // writer only drains every other cycle while the reader competes
            for (int i = 0; i < 8; i++)
            begin
                wdata = rand_word();
                i_wr_valid = 1'b1;
                i_wr_addr  = 4'(8 + i);
                i_wr_data  = wdata;
                check_eq("o_wr_full", 16'(o_wr_full), 16'(i == DROP_PULSE));
                if (i != DROP_PULSE)
                    model[4'(8 + i)] = wdata;   // the full queue drops this pulse
                next_cycle();
            end
            i_wr_valid = 1'b0;
        end
        wait_for(W_BLOCK, "the read block to finish");
        repeat (4) next_cycle();        // room for any stray result
        check_eq("result count", 16'(n_results), 16'(len));
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk)
    begin
        if (rst_n && o_valid)
        begin
            n_results++;
            assert (exp_q.size() != 0)
            else
            begin
                $display("result appeared with no read outstanding");
                proto_errs++;
            end
            if (exp_q.size() != 0)
                check_eq("o_data", 16'(o_data), 16'(exp_q.pop_front()));
        end
    end

    initial
    begin
        int sva_fails;
        rst_n      = 1'b0;
        i_wr_valid = 1'b0;
        i_wr_addr  = '0;
        i_wr_data  = '0;
        i_rd_start = 1'b0;
        i_rd_base  = '0;
        i_rd_count = '0;
        i_cmd      = '0;
        repeat (2) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        check_eq("o_valid", 16'(o_valid), 16'h0);
        check_eq("o_rd_busy", 16'(o_rd_busy), 16'h0);
        check_eq("o_wr_full", 16'(o_wr_full), 16'h0);
        check_eq("o_wr_idle", 16'(o_wr_idle), 16'h1);
        check_eq("o_data", 16'(o_data), 16'h0);
        for (int a = 0; a < 16; a++)
            write_word(4'(a), rand_word());
        wait_for(W_IDLE, "the write queue to drain");
        run_block(4'd0, 4'd0, {quant_pkg::MODE_LOW, 3'd0}, 0);  // zero count is 16 words
        for (int s = 0; s < 8; s++)
            run_block(4'((s * 5) % 16), 4'd10, {quant_pkg::MODE_SHIFT, 3'(s)}, 0);
        run_block(4'd0, 4'd8, {quant_pkg::MODE_LOW, 3'd0}, 2);  // writes hit 8..15 only
        wait_for(W_IDLE, "the write queue to drain");
        run_block(4'd8, 4'd8, {quant_pkg::MODE_LOW, 3'd0}, 0);  // dropped write left no trace
        run_block(4'd4, 4'd12, {quant_pkg::MODE_SHIFT, 3'd5}, 1);
        sva_fails = i_quant_out_top.i_quant_out_sva.fail_count;
        $display("value errors %0d, protocol errors %0d, timeouts %0d, assertion failures %0d",
                 value_errs, proto_errs, timeouts, sva_fails);
        if (value_errs + proto_errs + timeouts + sva_fails == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

// ==== verilog/bit_select_16x8.sv ====
module bit_select_16x8
(
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         i_valid,
    input  logic [quant_pkg::DATA_W-1:0] i_data_bus,
    input  logic [quant_pkg::CMD_W-1:0]  i_cmd,
    output logic                         o_valid,
    output logic [quant_pkg::OUT_W-1:0]  o_data_bus
);

    quant_pkg::sel_mode_e          mode;
    logic [quant_pkg::SHIFT_W-1:0] shift;
    logic [quant_pkg::SHIFT_W:0]   lsb;     // first bit of the shifted window

    assign mode  = quant_pkg::sel_mode_e'(i_cmd[quant_pkg::CMD_W-1]);
    assign shift = i_cmd[quant_pkg::SHIFT_W-1:0];
    assign lsb   = {1'b0, shift} + 1'b1;    // shift 7 selects bits 15..8

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            o_valid    <= 1'b0;
            o_data_bus <= '0;
        end
        else if (i_valid)
        begin
            o_valid <= 1'b1;
            case (mode)
                quant_pkg::MODE_LOW:
                begin
                    o_data_bus <= i_data_bus[quant_pkg::OUT_W-1:0];
                end
                quant_pkg::MODE_SHIFT:
                begin
                    o_data_bus <= i_data_bus[lsb +: quant_pkg::OUT_W];
                end
                default:
                begin
                    o_data_bus <= i_data_bus[quant_pkg::OUT_W-1:0];
                end
            endcase
        end
        else
        begin
            // idle cycles output zeros
            o_valid    <= 1'b0;
            o_data_bus <= '0;
        end
    end

endmodule

// ==== verilog/psum_arbiter.sv ====
module psum_arbiter
(
    input  logic       clk,
    input  logic       rst_n,
    psum_bus_if.arbiter wr_bus,
    psum_bus_if.arbiter rd_bus
);

    logic [quant_pkg::DATA_W-1:0] mem [psum_buf_pkg::BUF_DEPTH];

    psum_buf_pkg::grant_e last_q;   // winner of the previous grant
    psum_buf_pkg::grant_e rsel_q;   // who issued the pending read
    logic                 rvalid_q;
    logic [quant_pkg::DATA_W-1:0] rdata_q;

    logic                          gnt_wr;
    logic                          gnt_rd;
    logic                          acc_en;
    logic                          acc_we;
    logic [psum_buf_pkg::ADDR_W-1:0] acc_addr;
    logic [quant_pkg::DATA_W-1:0]  acc_wdata;

    // writer wins unless the reader also asks and the writer won last
    assign gnt_wr = wr_bus.req && (!rd_bus.req || last_q == psum_buf_pkg::GNT_READER);
    assign gnt_rd = rd_bus.req && !gnt_wr;

    assign wr_bus.gnt = gnt_wr;
    assign rd_bus.gnt = gnt_rd;

    // single port muxed by the winner
    assign acc_en    = gnt_wr | gnt_rd;
    assign acc_we    = gnt_wr ? wr_bus.we    : rd_bus.we;
    assign acc_addr  = gnt_wr ? wr_bus.addr  : rd_bus.addr;
    assign acc_wdata = gnt_wr ? wr_bus.wdata : rd_bus.wdata;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            last_q   <= psum_buf_pkg::GNT_READER;  // writer goes first
            rsel_q   <= psum_buf_pkg::GNT_READER;
            rvalid_q <= 1'b0;
        end
        else
        begin
            if (gnt_wr)
                last_q <= psum_buf_pkg::GNT_WRITER;
            else if (gnt_rd)
                last_q <= psum_buf_pkg::GNT_READER;
            rvalid_q <= acc_en && !acc_we;
            if (acc_en && !acc_we)
                rsel_q <= gnt_wr ? psum_buf_pkg::GNT_WRITER : psum_buf_pkg::GNT_READER;
        end
    end

    always_ff @(posedge clk)
    begin
        if (acc_en && acc_we)
            mem[acc_addr] <= acc_wdata;
        if (acc_en && !acc_we)
            rdata_q <= mem[acc_addr];   // registered read port
    end

    // read return goes only to the requester that issued it
    assign wr_bus.rvalid = rvalid_q && (rsel_q == psum_buf_pkg::GNT_WRITER);
    assign rd_bus.rvalid = rvalid_q && (rsel_q == psum_buf_pkg::GNT_READER);
    assign wr_bus.rdata  = rdata_q;
    assign rd_bus.rdata  = rdata_q;

endmodule

// ==== verilog/psum_buf_pkg.sv ====
package psum_buf_pkg;

    localparam int BUF_DEPTH   = 16;  // partial-sum buffer entries
    localparam int ADDR_W      = 4;   // buffer address width
    localparam int QUEUE_DEPTH = 4;   // writer pending queue entries

    // last winner of the buffer arbiter
    typedef enum logic
    {
        GNT_WRITER = 1'b0,
        GNT_READER = 1'b1
    } grant_e;

    typedef enum logic
    {
        RD_IDLE  = 1'b0,
        RD_ISSUE = 1'b1
    } rd_state_e;

endpackage

// ==== verilog/psum_bus_if.sv ====
interface psum_bus_if;

    logic                           req;    // access request
    logic                           we;     // 1 = write, 0 = read
    logic [psum_buf_pkg::ADDR_W-1:0] addr;
    logic [quant_pkg::DATA_W-1:0]   wdata;
    logic                           gnt;    // one access this cycle
    logic                           rvalid; // read data one cycle after grant
    logic [quant_pkg::DATA_W-1:0]   rdata;

    modport requester
    (
        output req, we, addr, wdata,
        input  gnt, rvalid, rdata
    );

    modport arbiter
    (
        input  req, we, addr, wdata,
        output gnt, rvalid, rdata
    );

endinterface

// ==== verilog/psum_writer.sv ====
module psum_writer
(
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            i_wr_valid,
    input  logic [psum_buf_pkg::ADDR_W-1:0] i_wr_addr,
    input  logic [quant_pkg::DATA_W-1:0]    i_wr_data,
    output logic                            o_wr_full,
    output logic                            o_wr_idle,
    psum_bus_if.requester                   bus
);

    logic [psum_buf_pkg::ADDR_W-1:0] addr_mem [psum_buf_pkg::QUEUE_DEPTH];
    logic [quant_pkg::DATA_W-1:0]    data_mem [psum_buf_pkg::QUEUE_DEPTH];

    logic [$clog2(psum_buf_pkg::QUEUE_DEPTH)-1:0] head_q;
    logic [$clog2(psum_buf_pkg::QUEUE_DEPTH)-1:0] tail_q;
    logic [$clog2(psum_buf_pkg::QUEUE_DEPTH):0]   count_q;

    logic enq;
    logic deq;

    assign o_wr_full = (count_q == psum_buf_pkg::QUEUE_DEPTH);
    assign o_wr_idle = (count_q == '0);

    assign enq = i_wr_valid && !o_wr_full;  // pulses while full are lost
    assign deq = bus.gnt;                   // head retires on grant

    // head entry is always on the bus while the queue holds anything
    assign bus.req   = !o_wr_idle;
    assign bus.we    = 1'b1;
    assign bus.addr  = addr_mem[head_q];
    assign bus.wdata = data_mem[head_q];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end
        else
        begin
            if (enq)
                tail_q <= tail_q + 1'b1;    // wraps at queue depth
            if (deq)
                head_q <= head_q + 1'b1;
            if (enq && !deq)
                count_q <= count_q + 1'b1;
            else if (deq && !enq)
                count_q <= count_q - 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (enq)
        begin
            addr_mem[tail_q] <= i_wr_addr;
            data_mem[tail_q] <= i_wr_data;
        end
    end

endmodule

// ==== verilog/quant_out_top.sv ====
module quant_out_top
(
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            i_wr_valid,
    input  logic [psum_buf_pkg::ADDR_W-1:0] i_wr_addr,
    input  logic [quant_pkg::DATA_W-1:0]    i_wr_data,
    output logic                            o_wr_full,
    output logic                            o_wr_idle,
    input  logic                            i_rd_start,
    input  logic [psum_buf_pkg::ADDR_W-1:0] i_rd_base,
    input  logic [psum_buf_pkg::ADDR_W-1:0] i_rd_count,
    input  logic [quant_pkg::CMD_W-1:0]     i_cmd,
    output logic                            o_rd_busy,
    output logic                            o_valid,
    output logic [quant_pkg::OUT_W-1:0]     o_data
);

    psum_bus_if wr_bus ();
    psum_bus_if rd_bus ();

    logic                         sel_valid;
    logic [quant_pkg::DATA_W-1:0] sel_word;
    logic [quant_pkg::CMD_W-1:0]  sel_cmd;

    psum_writer i_psum_writer
    (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_wr_valid (i_wr_valid),
        .i_wr_addr  (i_wr_addr),
        .i_wr_data  (i_wr_data),
        .o_wr_full  (o_wr_full),
        .o_wr_idle  (o_wr_idle),
        .bus        (wr_bus.requester)
    );

    quant_reader i_quant_reader
    (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_rd_start  (i_rd_start),
        .i_rd_base   (i_rd_base),
        .i_rd_count  (i_rd_count),
        .i_cmd       (i_cmd),
        .o_rd_busy   (o_rd_busy),
        .bus         (rd_bus.requester),
        .o_sel_valid (sel_valid),
        .o_sel_word  (sel_word),
        .o_sel_cmd   (sel_cmd)
    );

    psum_arbiter i_psum_arbiter
    (
        .clk    (clk),
        .rst_n  (rst_n),
        .wr_bus (wr_bus.arbiter),
        .rd_bus (rd_bus.arbiter)
    );

    bit_select_16x8 i_bit_select
    (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_valid    (sel_valid),
        .i_data_bus (sel_word),
        .i_cmd      (sel_cmd),
        .o_valid    (o_valid),
        .o_data_bus (o_data)
    );

endmodule

// ==== verilog/quant_pkg.sv ====
package quant_pkg;

    localparam int DATA_W  = 16;  // partial sum width
    localparam int OUT_W   = 8;   // selected output width
    localparam int CMD_W   = 4;   // mode bit plus shift field
    localparam int SHIFT_W = 3;   // shift field in cmd[2:0]

    // top bit of the selection command
    typedef enum logic
    {
        MODE_LOW   = 1'b0,  // keep bits 7..0
        MODE_SHIFT = 1'b1   // window starting at shift+1
    } sel_mode_e;

endpackage

// ==== verilog/quant_reader.sv ====
module quant_reader
(
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            i_rd_start,
    input  logic [psum_buf_pkg::ADDR_W-1:0] i_rd_base,
    input  logic [psum_buf_pkg::ADDR_W-1:0] i_rd_count,
    input  logic [quant_pkg::CMD_W-1:0]     i_cmd,
    output logic                            o_rd_busy,
    psum_bus_if.requester                   bus,
    output logic                            o_sel_valid,
    output logic [quant_pkg::DATA_W-1:0]    o_sel_word,
    output logic [quant_pkg::CMD_W-1:0]     o_sel_cmd
);

    psum_buf_pkg::rd_state_e state_q;

    logic [psum_buf_pkg::ADDR_W-1:0] addr_q;    // next address to read
    logic [psum_buf_pkg::ADDR_W:0]   remain_q;  // grants still needed
    logic [quant_pkg::CMD_W-1:0]     cmd_q;
    logic [psum_buf_pkg::ADDR_W:0]   block_len;

    // zero count asks for the whole buffer
    assign block_len = (i_rd_count == '0)
                     ? (psum_buf_pkg::ADDR_W+1)'(psum_buf_pkg::BUF_DEPTH)
                     : {1'b0, i_rd_count};

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state_q  <= psum_buf_pkg::RD_IDLE;
            addr_q   <= '0;
            remain_q <= '0;
            cmd_q    <= '0;
        end
        else
        begin
            case (state_q)
                psum_buf_pkg::RD_IDLE:
                begin
                    if (i_rd_start)
                    begin
                        addr_q   <= i_rd_base;
                        remain_q <= block_len;
                        cmd_q    <= i_cmd;  // held for the whole block
                        state_q  <= psum_buf_pkg::RD_ISSUE;
                    end
                end
                psum_buf_pkg::RD_ISSUE:
                begin
                    if (bus.gnt)
                    begin
                        addr_q   <= addr_q + 1'b1;  // wraps modulo 16
                        remain_q <= remain_q - 1'b1;
                        if (remain_q == 1)
                            state_q <= psum_buf_pkg::RD_IDLE;
                    end
                end
                default:
                begin
                    state_q <= psum_buf_pkg::RD_IDLE;
                end
            endcase
        end
    end

    assign o_rd_busy = (state_q == psum_buf_pkg::RD_ISSUE);

    // read-only requester
    assign bus.req   = o_rd_busy;
    assign bus.we    = 1'b0;
    assign bus.addr  = addr_q;
    assign bus.wdata = '0;

    assign o_sel_valid = bus.rvalid;
    assign o_sel_word  = bus.rdata;
    assign o_sel_cmd   = cmd_q;

endmodule
